// ==== verilog/pito_pkg.sv ====
package pito_pkg;

    // Data path width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] pito_word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      byte_en_t;

    // Instruction kind, immediate forms share the register form
    // NOP sits at zero so a cleared stage holds a bubble
    typedef enum logic [5:0] {
        NOP = 6'd0,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR, LUI, AUIPC
    } pito_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_XOR, ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // ========================================================================
    // Instruction formats
    // ========================================================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, read through the view its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } pito_instr_u;

    // ========================================================================
    // Stage payloads
    // ========================================================================
    typedef struct packed {
        pito_opcode_e kind;
        alu_op_e      alu_op;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        reg_addr_t    rd;
        logic [4:0]   shamt;
        pito_word_t   imm;
        logic         uses_rs2;
    } dec_instr_t;

    // Execute to memory stage
    typedef struct packed {
        pito_opcode_e kind;
        reg_addr_t    rd;
        pito_word_t   pc;
        pito_word_t   imm;
        pito_word_t   rs1;
        pito_word_t   rs2;
    } ex_stage_t;

    typedef struct packed {
        pito_word_t addr;
        pito_word_t wdata;
        byte_en_t   be;
        logic       we;
        logic       req;
    } dmem_req_t;

    // Hart field is wide enough for 16 harts
    typedef struct packed {
        logic [3:0] hart;
        logic       en;
        reg_addr_t  idx;
        pito_word_t data;
    } rf_write_t;

endpackage

// ==== verilog/pito_alu.sv ====
`timescale 1ns/1ps

module pito_alu (
    input  pito_pkg::pito_word_t a,
    input  pito_pkg::pito_word_t b,
    input  pito_pkg::alu_op_e    op,
    output pito_pkg::pito_word_t res,
    output logic                 zero
);
    import pito_pkg::*;

    // Shifts use only the low five bits of b
    logic [4:0] sh;

    assign sh = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_SLL:  res = a << sh;
            ALU_SRL:  res = a >> sh;
            ALU_SRA:  res = $signed(a) >>> sh;
            ALU_XOR:  res = a ^ b;
            ALU_OR:   res = a | b;
            ALU_AND:  res = a & b;
            ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: res = {31'b0, a < b};
            default:  res = '0;
        endcase
    end

    assign zero = (res == '0);

endmodule

// ==== verilog/pito_decoder.sv ====
`timescale 1ns/1ps

module pito_decoder (
    input  pito_pkg::pito_word_t instr,
    output pito_pkg::dec_instr_t dec
);
    import pito_pkg::*;

    pito_instr_u iw;
    logic        is_r;
    logic        alt;

    assign iw   = instr;
    assign is_r = (iw.r.opcode == 7'b0110011);
    // funct7 bit 5 picks SUB or SRA, immediates only use it on shifts
    assign alt  = iw.r.funct7[5] && (is_r || iw.r.funct3 == 3'b101);

    always_comb begin
        dec          = '0;
        dec.kind     = NOP;
        dec.alu_op   = ALU_ADD;
        dec.rs1      = iw.r.rs1;
        dec.rs2      = iw.r.rs2;
        dec.rd       = iw.r.rd;
        // Shift amount shares the rs2 bit field
        dec.shamt    = iw.r.rs2;
        case (iw.r.opcode)
            // Register and immediate arithmetic
            7'b0110011, 7'b0010011: begin
                dec.uses_rs2 = is_r;
                dec.imm      = {{20{iw.i.imm[11]}}, iw.i.imm};
                case (iw.r.funct3)
                    3'b000: {dec.kind, dec.alu_op} = alt ? {SUB, ALU_SUB} : {ADD, ALU_ADD};
                    3'b001: {dec.kind, dec.alu_op} = {SLL, ALU_SLL};
                    3'b010: {dec.kind, dec.alu_op} = {SLT, ALU_SLT};
                    3'b011: {dec.kind, dec.alu_op} = {SLTU, ALU_SLTU};
                    3'b100: {dec.kind, dec.alu_op} = {XOR, ALU_XOR};
                    3'b101: {dec.kind, dec.alu_op} = alt ? {SRA, ALU_SRA} : {SRL, ALU_SRL};
                    3'b110: {dec.kind, dec.alu_op} = {OR, ALU_OR};
                    default: {dec.kind, dec.alu_op} = {AND, ALU_AND};
                endcase
                // Only 0 and 0100000 are legal funct7 values
                if (is_r && iw.r.funct7 != 7'b0 && iw.r.funct7 != 7'b0100000)
                    dec.kind = NOP;
            end
            // Loads
            7'b0000011: begin
                dec.imm = {{20{iw.i.imm[11]}}, iw.i.imm};
                case (iw.i.funct3)
                    3'b000:  dec.kind = LB;
                    3'b001:  dec.kind = LH;
                    3'b010:  dec.kind = LW;
                    3'b100:  dec.kind = LBU;
                    3'b101:  dec.kind = LHU;
                    default: dec.kind = NOP;
                endcase
            end
            // Stores
            7'b0100011: begin
                dec.imm = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
                case (iw.s.funct3)
                    3'b000:  dec.kind = SB;
                    3'b001:  dec.kind = SH;
                    3'b010:  dec.kind = SW;
                    default: dec.kind = NOP;
                endcase
            end
            // Branches
            7'b1100011: begin
                dec.uses_rs2 = 1'b1;
                dec.imm      = {{20{iw.b.imm12}}, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
                case (iw.b.funct3)
                    3'b000:  dec.kind = BEQ;
                    3'b001:  dec.kind = BNE;
                    3'b100:  dec.kind = BLT;
                    3'b101:  dec.kind = BGE;
                    3'b110:  dec.kind = BLTU;
                    3'b111:  dec.kind = BGEU;
                    default: dec.kind = NOP;
                endcase
            end
            7'b1101111: begin
                dec.kind = JAL;
                dec.imm  = {{12{iw.j.imm20}}, iw.j.imm19_12, iw.j.imm11, iw.j.imm10_1, 1'b0};
            end
            // JALR target goes through the ALU adder
            7'b1100111: begin
                dec.kind = (iw.i.funct3 == 3'b000) ? JALR : NOP;
                dec.imm  = {{20{iw.i.imm[11]}}, iw.i.imm};
            end
            7'b0110111: begin
                dec.kind = LUI;
                dec.imm  = {iw.u.imm, 12'b0};
            end
            7'b0010111: begin
                dec.kind = AUIPC;
                dec.imm  = {iw.u.imm, 12'b0};
            end
            default: dec.kind = NOP;
        endcase
    end

endmodule

// ==== verilog/pito_regfile.sv ====
`timescale 1ns/1ps

module pito_regfile #(
    parameter int num_harts = 8
) (
    input  logic                         clk,
    input  logic [$clog2(num_harts)-1:0] rd_hart,
    input  pito_pkg::reg_addr_t          ra1,
    input  pito_pkg::reg_addr_t          ra2,
    output pito_pkg::pito_word_t         rd1,
    output pito_pkg::pito_word_t         rd2,
    input  pito_pkg::rf_write_t          wr
);
    import pito_pkg::*;

    localparam int hw = $clog2(num_harts);

    // Banks stacked back to back, hart index in the upper address bits
    pito_word_t bank [num_harts*32];

    always_ff @(posedge clk) begin
        // x0 is never stored and always reads zero
        rd1 <= (ra1 == '0) ? '0 : bank[{rd_hart, ra1}];
        rd2 <= (ra2 == '0) ? '0 : bank[{rd_hart, ra2}];
        if (wr.en && wr.idx != '0)
            bank[{wr.hart[hw-1:0], wr.idx}] <= wr.data;
    end

endmodule

// ==== verilog/pito_lsu.sv ====
`timescale 1ns/1ps

module pito_lsu (
    input  logic                 clk,
    input  pito_pkg::ex_stage_t  ex,
    input  pito_pkg::pito_word_t addr,
    output pito_pkg::dmem_req_t  dmem,
    input  pito_pkg::pito_word_t dmem_rdata,
    output pito_pkg::pito_word_t load_val
);
    import pito_pkg::*;

    logic         is_load, is_store;
    pito_opcode_e ld_kind;
    logic [1:0]   ld_off;
    logic [7:0]   ld_byte;
    logic [15:0]  ld_half;

    assign is_load  = ex.kind inside {LB, LH, LW, LBU, LHU};
    assign is_store = ex.kind inside {SB, SH, SW};

    // ========================================================================
    // Store side
    // ========================================================================
    always_comb begin
        dmem.addr = addr;
        dmem.req  = is_load || is_store;
        dmem.we   = is_store;
        // Data is copied to every lane, enables pick the live ones
        case (ex.kind)
            SB: begin
                dmem.wdata = {4{ex.rs2[7:0]}};
                dmem.be    = 4'b0001 << addr[1:0];
            end
            SH: begin
                dmem.wdata = {2{ex.rs2[15:0]}};
                dmem.be    = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmem.wdata = ex.rs2;
                dmem.be    = 4'b1111;
            end
        endcase
    end

    // ========================================================================
    // Load side
    // ========================================================================
    // Kind and offset wait one cycle for the read data
    always_ff @(posedge clk) begin
        ld_kind <= ex.kind;
        ld_off  <= addr[1:0];
    end

    assign ld_byte = dmem_rdata[8*ld_off +: 8];
    assign ld_half = dmem_rdata[16*ld_off[1] +: 16];

    always_comb begin
        case (ld_kind)
            LB:      load_val = {{24{ld_byte[7]}}, ld_byte};
            LBU:     load_val = {24'b0, ld_byte};
            LH:      load_val = {{16{ld_half[15]}}, ld_half};
            LHU:     load_val = {16'b0, ld_half};
            default: load_val = dmem_rdata;
        endcase
    end

endmodule

// ==== verilog/pito_next_pc.sv ====
`timescale 1ns/1ps

module pito_next_pc (
    input  pito_pkg::ex_stage_t  ex,
    input  pito_pkg::pito_word_t alu_res,
    output logic                 taken,
    output pito_pkg::pito_word_t target,
    output pito_pkg::pito_word_t link
);
    import pito_pkg::*;

    pito_word_t pc_rel;

    // Shared pc relative sum for branches, JAL and AUIPC
    assign pc_rel = ex.pc + ex.imm;

    always_comb begin
        case (ex.kind)
            BEQ:       taken = (ex.rs1 == ex.rs2);
            BNE:       taken = (ex.rs1 != ex.rs2);
            BLT:       taken = ($signed(ex.rs1) < $signed(ex.rs2));
            BGE:       taken = ($signed(ex.rs1) >= $signed(ex.rs2));
            BLTU:      taken = (ex.rs1 < ex.rs2);
            BGEU:      taken = (ex.rs1 >= ex.rs2);
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // JALR takes rs1 plus imm from the ALU, low bit cleared
    assign target = (ex.kind == JALR) ? {alu_res[31:1], 1'b0} : pc_rel;

    // Jumps link pc+4, AUIPC rides the same write-back path
    assign link = (ex.kind == AUIPC) ? pc_rel : ex.pc + 32'd4;

endmodule

// ==== verilog/pito_barrel_ctrl.sv ====
`timescale 1ns/1ps

module pito_barrel_ctrl #(
    parameter int                   num_harts  = 8,
    parameter pito_pkg::pito_word_t reset_addr = '0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    output pito_pkg::pito_word_t              imem_addr,
    input  pito_pkg::dec_instr_t              dec,
    input  pito_pkg::pito_word_t              rd1,
    input  pito_pkg::pito_word_t              rd2,
    output logic [$clog2(num_harts)-1:0]      dec_hart,
    output pito_pkg::pito_word_t              alu_a,
    output pito_pkg::pito_word_t              alu_b,
    output pito_pkg::alu_op_e                 alu_op,
    input  pito_pkg::pito_word_t              alu_res,
    output pito_pkg::ex_stage_t               ex,
    output pito_pkg::pito_word_t              ex_res,
    input  pito_pkg::pito_word_t              load_val,
    input  logic                              br_taken,
    input  pito_pkg::pito_word_t              br_target,
    input  pito_pkg::pito_word_t              link_val,
    output pito_pkg::rf_write_t               rf_wr
);
    import pito_pkg::*;

    localparam int hw = $clog2(num_harts);

    // Hart tags, one per stage
    logic [hw-1:0]        hart_cnt, f_hart, d_hart, e_hart, w_hart;
    pito_word_t           pc [num_harts];
    pito_word_t           pend_tgt [num_harts];
    logic [num_harts-1:0] pend_vld;
    pito_word_t           fetch_pc, f_pc, d_pc;
    logic                 f_valid;
    dec_instr_t           d_dec;

    // Memory to write-back payload
    pito_opcode_e         w_kind;
    reg_addr_t            w_rd;
    pito_word_t           w_imm, w_alu, w_link, w_target;
    logic                 w_taken;

    // ========================================================================
    // Fetch and per-hart PCs
    // ========================================================================
    // A taken redirect overrides the sequential PC
    assign fetch_pc  = pend_vld[hart_cnt] ? pend_tgt[hart_cnt] : pc[hart_cnt];
    assign imem_addr = fetch_pc >> 2;
    assign dec_hart  = f_hart;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hart_cnt <= '0;
            pend_vld <= '0;
            for (int i = 0; i < num_harts; i++) begin
                pc[i] <= reset_addr;
            end
        end else begin
            // Wraps on its own, hart count is a power of two
            hart_cnt           <= hart_cnt + 1'b1;
            pc[hart_cnt]       <= fetch_pc + 32'd4;
            pend_vld[hart_cnt] <= 1'b0;
            // Write-back hart never equals the fetch hart
            if (w_taken) begin
                pend_vld[w_hart] <= 1'b1;
                pend_tgt[w_hart] <= w_target;
            end
        end
    end

    // ========================================================================
    // Execute operands
    // ========================================================================
    assign alu_a  = rd1;
    assign alu_op = d_dec.alu_op;

    always_comb begin
        if (d_dec.uses_rs2)
            alu_b = rd2;
        else if (d_dec.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA})
            alu_b = {27'b0, d_dec.shamt};
        else
            alu_b = d_dec.imm;
    end

    // ========================================================================
    // Stage registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f_valid    <= 1'b0;
            d_dec.kind <= NOP;
            ex.kind    <= NOP;
            w_kind     <= NOP;
            w_taken    <= 1'b0;
            rf_wr.en   <= 1'b0;
        end else begin
            // Fetch to decode
            f_valid <= 1'b1;
            f_hart  <= hart_cnt;
            f_pc    <= fetch_pc;
            // Decode to execute, bubble until the first fetch lands
            d_dec   <= f_valid ? dec : '0;
            d_hart  <= f_hart;
            d_pc    <= f_pc;
            // Execute to memory
            ex.kind <= d_dec.kind;
            ex.rd   <= d_dec.rd;
            ex.pc   <= d_pc;
            ex.imm  <= d_dec.imm;
            ex.rs1  <= rd1;
            ex.rs2  <= rd2;
            ex_res  <= alu_res;
            e_hart  <= d_hart;
            // Memory to write-back
            w_kind   <= ex.kind;
            w_rd     <= ex.rd;
            w_imm    <= ex.imm;
            w_alu    <= ex_res;
            w_link   <= link_val;
            w_target <= br_target;
            w_taken  <= br_taken;
            w_hart   <= e_hart;
            // Register write, branches and stores leave the file alone
            rf_wr.en   <= !(w_kind inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BGE, BLTU, BGEU});
            rf_wr.hart <= 4'(w_hart);
            rf_wr.idx  <= w_rd;
            if (w_kind == LUI)
                rf_wr.data <= w_imm;
            else if (w_kind inside {JAL, JALR, AUIPC})
                rf_wr.data <= w_link;
            else if (w_kind inside {LB, LH, LW, LBU, LHU})
                rf_wr.data <= load_val;
            else
                rf_wr.data <= w_alu;
        end
    end

endmodule

// ==== verilog/pito_core.sv ====
`timescale 1ns/1ps

module pito_core #(
    parameter int                   num_harts  = 8,
    parameter pito_pkg::pito_word_t reset_addr = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output pito_pkg::pito_word_t imem_addr,
    input  pito_pkg::pito_word_t imem_rdata,
    output pito_pkg::dmem_req_t  dmem,
    input  pito_pkg::pito_word_t dmem_rdata
);
    import pito_pkg::*;

    localparam int hw = $clog2(num_harts);

    // Decode side
    dec_instr_t      dec;
    logic [hw-1:0]   dec_hart;
    pito_word_t      rd1, rd2;

    // Execute and memory side
    pito_word_t      alu_a, alu_b, alu_res, ex_res;
    alu_op_e         alu_op;
    ex_stage_t       ex;
    pito_word_t      load_val;
    logic            br_taken;
    pito_word_t      br_target, link_val;
    rf_write_t       rf_wr;

    pito_barrel_ctrl #(.num_harts(num_harts), .reset_addr(reset_addr)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr),
        .dec(dec), .rd1(rd1), .rd2(rd2), .dec_hart(dec_hart),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_res(alu_res),
        .ex(ex), .ex_res(ex_res), .load_val(load_val),
        .br_taken(br_taken), .br_target(br_target), .link_val(link_val),
        .rf_wr(rf_wr)
    );

    // Instruction word is decoded straight off the memory bus
    pito_decoder u_dec (.instr(imem_rdata), .dec(dec));

    pito_regfile #(.num_harts(num_harts)) u_rf (
        .clk(clk), .rd_hart(dec_hart), .ra1(dec.rs1), .ra2(dec.rs2),
        .rd1(rd1), .rd2(rd2), .wr(rf_wr)
    );

    pito_alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .res(alu_res), .zero());

    pito_lsu u_lsu (
        .clk(clk), .ex(ex), .addr(ex_res), .dmem(dmem),
        .dmem_rdata(dmem_rdata), .load_val(load_val)
    );

    pito_next_pc u_npc (
        .ex(ex), .alu_res(ex_res), .taken(br_taken),
        .target(br_target), .link(link_val)
    );

endmodule

// ==== dv/pito_clk_gen.sv ====
`timescale 1ns/1ps

module pito_clk_gen #(
    parameter int half_period = 10
) (
    output logic clk
);

    // Free running clock, 20 ns period
    initial clk = 1'b0;

    always #(half_period) clk = ~clk;

endmodule

// ==== dv/pito_tb.sv ====
`timescale 1ns/1ps

module pito_tb;
    import pito_pkg::*;

    localparam int         num_harts      = 8;
    localparam pito_word_t reset_addr     = 32'h0;
    localparam int         imem_words     = 64;
    localparam int         dmem_words     = 64;
    localparam int         timeout_margin = 64;
    localparam             input_file     = "dv/core_input.txt";

    logic       clk;
    logic       rst_n;
    pito_word_t imem_addr;
    pito_word_t imem_rdata;
    dmem_req_t  dmem;
    pito_word_t dmem_rdata;

    // Memory models and expected stores
    pito_word_t imem [imem_words];
    pito_word_t dmem_mem [dmem_words];
    dmem_req_t  exp_q [$];
    integer     seed;
    int         prog_len;
    int         cycle;
    int         timeout_cycles;
    int         store_idx;
    int         hart_seen;

    pito_clk_gen u_clk_gen (.clk(clk));

    pito_core #(.num_harts(num_harts), .reset_addr(reset_addr)) i_pito_core (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem(dmem), .dmem_rdata(dmem_rdata)
    );

    // ========================================================================
    // Failure reporting and checks
    // ========================================================================
    task automatic fail_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_fetch(string name, pito_word_t exp, pito_word_t act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    // Only the enabled lanes of the write data carry meaning
    task automatic check_store(string name, dmem_req_t exp, dmem_req_t act);
        logic  ok;
        string msg;
        ok = (act.addr === exp.addr) && (act.be === exp.be) &&
             (act.we === exp.we) && (act.req === exp.req);
        for (int i = 0; i < 4; i++) begin
            if (exp.be[i] && act.wdata[8*i +: 8] !== exp.wdata[8*i +: 8])
                ok = 1'b0;
        end
        if (!ok) begin
            msg = $sformatf("CHECK FAILED %s: expected addr %h data %h be %b we %b req %b",
                name, exp.addr, exp.wdata, exp.be, exp.we, exp.req);
            msg = $sformatf("%s, actual addr %h data %h be %b we %b req %b",
                msg, act.addr, act.wdata, act.be, act.we, act.req);
            fail_run(msg);
        end
    endtask

    // ========================================================================
    // Data file
    // ========================================================================
    // P records fill the program, S records queue expected stores,
    // anything after the fields on a line is a comment
    task automatic load_input();
        int               fd;
        int               code;
        logic             done;
        logic [7:0]       tag;
        logic [8*128-1:0] rest;
        pito_word_t       a, d, be;
        dmem_req_t        rec;
        fd = $fopen(input_file, "r");
        if (fd == 0)
            fail_run("Cannot open the stimulus file dv/core_input.txt");
        done     = 1'b0;
        prog_len = 0;
        while (!done) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (tag)
                    "#": code = $fgets(rest, fd);
                    "P": begin
                        code = $fscanf(fd, "%h %h", a, d);
                        if (code != 2 || a >= imem_words)
                            fail_run("A program record in the stimulus file is malformed");
                        imem[a]  = d;
                        prog_len = prog_len + 1;
                        code     = $fgets(rest, fd);
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h %h", a, d, be);
                        if (code != 3)
                            fail_run("A store record in the stimulus file is malformed");
                        rec.addr  = a;
                        rec.wdata = d;
                        rec.be    = be[3:0];
                        rec.we    = 1'b1;
                        rec.req   = 1'b1;
                        exp_q.push_back(rec);
                        code = $fgets(rest, fd);
                    end
                    default: fail_run("The stimulus file holds an unknown record type");
                endcase
            end
        end
        $fclose(fd);
    endtask

    // ========================================================================
    // Memory models
    // ========================================================================
    // Both answer one cycle after the request
    always @(posedge clk) begin
        imem_rdata <= imem[imem_addr[$clog2(imem_words)-1:0]];
        if (dmem.req === 1'b1) begin
            dmem_rdata <= dmem_mem[dmem.addr[$clog2(dmem_words)+1:2]];
            if (dmem.we === 1'b1) begin
                for (int i = 0; i < 4; i++) begin
                    if (dmem.be[i])
                        dmem_mem[dmem.addr[$clog2(dmem_words)+1:2]][8*i +: 8] <= dmem.wdata[8*i +: 8];
                end
            end
        end
    end

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        rst_n      = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        seed       = 32'hc6b6_20a1;
        cycle      = 0;
        store_idx  = 0;
        hart_seen  = 0;
        // Unused words are never fetched or loaded
        for (int i = 0; i < imem_words; i++)
            imem[i] = $random(seed);
        for (int i = 0; i < dmem_words; i++)
            dmem_mem[i] = $random(seed);
        load_input();
        timeout_cycles = prog_len * num_harts + timeout_margin;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Sample between rising edges, once per cycle
        while (exp_q.size() > 0) begin
            @(negedge clk);
            cycle = cycle + 1;
            if (cycle > timeout_cycles)
                fail_run($sformatf("Timeout after %0d cycles, %0d store records never seen",
                    cycle, exp_q.size()));
            // First round of fetches, every hart at the reset address
            if (cycle <= num_harts)
                check_fetch($sformatf("reset fetch hart %0d", cycle - 1), reset_addr >> 2,
                    imem_addr);
            // First instruction reaches the memory stage in cycle 4
            if (cycle <= 3 && dmem.req !== 1'b0)
                fail_run("Data memory request raised before any instruction reached memory");
            if (imem_addr >= imem_words)
                fail_run("Fetch address ran past the end of the program memory");
            if (dmem.req === 1'b1 && dmem.addr >= dmem_words * 4)
                fail_run("Data access outside the data memory");
            // Each record shows up once per hart, back to back
            if (dmem.we !== 1'b0) begin
                check_store($sformatf("store %0d hart %0d", store_idx, hart_seen),
                    exp_q[0], dmem);
                hart_seen = hart_seen + 1;
                if (hart_seen == num_harts) begin
                    hart_seen = 0;
                    store_idx = store_idx + 1;
                    void'(exp_q.pop_front());
                end
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== dv/core_input.txt ====
# P <instruction word address> <instruction>
# S <store byte address> <store data in its lanes> <byte enables>
P 00 123450b7   lui   x1, 0x12345
P 01 67808093   addi  x1, x1, 0x678
P 02 ffb00113   addi  x2, x0, -5
P 03 002081b3   add   x3, x1, x2
P 04 04302023   sw    x3, 0x40(x0)
S 00000040 12345673 f
P 05 40115213   srai  x4, x2, 1
P 06 00124233   xor   x4, x4, x1
P 07 04402223   sw    x4, 0x44(x0)
S 00000044 edcba985 f
P 08 001122b3   slt   x5, x2, x1
P 09 04502423   sw    x5, 0x48(x0)
S 00000048 00000001 f
P 0a 00001317   auipc x6, 0x1
P 0b 04602623   sw    x6, 0x4c(x0)
S 0000004c 00001028 f
P 0c 06100023   sb    x1, 0x60(x0)
S 00000060 00000078 1
P 0d 061000a3   sb    x1, 0x61(x0)
S 00000061 00007800 2
P 0e 06100123   sb    x1, 0x62(x0)
S 00000062 00780000 4
P 0f 062001a3   sb    x2, 0x63(x0)
S 00000063 fb000000 8
P 10 06101223   sh    x1, 0x64(x0)
S 00000064 00005678 3
P 11 06201323   sh    x2, 0x66(x0)
S 00000066 fffb0000 c
P 12 06300383   lb    x7, 0x63(x0)
P 13 04702823   sw    x7, 0x50(x0)
S 00000050 fffffffb f
P 14 06304383   lbu   x7, 0x63(x0)
P 15 04702a23   sw    x7, 0x54(x0)
S 00000054 000000fb f
P 16 06601383   lh    x7, 0x66(x0)
P 17 04702c23   sw    x7, 0x58(x0)
S 00000058 fffffffb f
P 18 06605383   lhu   x7, 0x66(x0)
P 19 04702e23   sw    x7, 0x5c(x0)
S 0000005c 0000fffb f
P 1a 06002383   lw    x7, 0x60(x0)
P 1b 06702423   sw    x7, 0x68(x0)
S 00000068 fb787878 f
P 1c 00108463   beq   x1, x1, +8
P 1d 06002623   sw    x0, 0x6c(x0)   skipped
P 1e 00109463   bne   x1, x1, +8     falls through
P 1f 008004ef   jal   x9, +8
P 20 06002623   sw    x0, 0x6c(x0)   skipped
P 21 06902623   sw    x9, 0x6c(x0)
S 0000006c 00000080 f
P 22 09900513   addi  x10, x0, 0x99
P 23 000505e7   jalr  x11, 0(x10)
P 24 06002823   sw    x0, 0x70(x0)   skipped
P 25 06002823   sw    x0, 0x70(x0)   skipped
P 26 06b02823   sw    x11, 0x70(x0)
S 00000070 00000090 f
P 27 0000006f   jal   x0, 0          park

// ==== verilog.f ====
verilog/pito_pkg.sv
verilog/pito_alu.sv
verilog/pito_decoder.sv
verilog/pito_regfile.sv
verilog/pito_lsu.sv
verilog/pito_next_pc.sv
verilog/pito_barrel_ctrl.sv
verilog/pito_core.sv
dv/pito_clk_gen.sv
dv/pito_tb.sv

// ==== Bender.yml ====
package:
  name: pito_barrel

sources:
  - verilog/pito_pkg.sv
  - verilog/pito_alu.sv
  - verilog/pito_decoder.sv
  - verilog/pito_regfile.sv
  - verilog/pito_lsu.sv
  - verilog/pito_next_pc.sv
  - verilog/pito_barrel_ctrl.sv
  - verilog/pito_core.sv
  - target: test
    files:
      - dv/pito_clk_gen.sv
      - dv/pito_tb.sv
